// File: filelist.f
+incdir+testbench
verilog/CoreTypes.sv
verilog/ResetSequencer.sv
verilog/MemoryAccessUnit.sv
verilog/RegFile.sv
verilog/DecodeStage.sv
verilog/ExecuteStage.sv
verilog/ResultStage.sv
verilog/Core.sv
testbench/CoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module CoreTb -f filelist.f -o CoreSim \
    && ./obj_dir/CoreSim | tee /dev/stderr | grep -q -F '** PASS **' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: testbench/CoreProgram.svh
`ifndef CORE_PROGRAM_SVH
`define CORE_PROGRAM_SVH

// Instruction builders, field layouts as in the RV32I base formats
function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
endfunction

function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
endfunction

function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] lui(input int rd, input int upper);
    return {upper[19:0], rd[4:0], 7'b0110111};
endfunction

function automatic logic [31:0] alu(input int funct7, input int funct3, input int rd,
                                    input int rs1, input int rs2);
    return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] branch(input int funct3, input int rs1, input int rs2,
                                       input int offset);
    return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3[2:0], offset[4:1],
            offset[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal(input int rd, input int offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'b1101111};
endfunction

localparam int ProgramLength = 55;

// x31 holds the host address, x6 the data area base
function automatic logic [31:0] programWord(input int index);
    case (index)
        0:  return addi(31, 0, CoreTypes::HostIoAddr);
        1:  return sw(31, 31, 0);
        2:  return sw(5, 31, 0);          // Never written, reads zero
        3:  return addi(12, 10, 32'h55);
        4:  return sw(12, 31, 0);
        5:  return sw(13, 31, 0);
        6:  return addi(1, 0, 7);
        7:  return addi(2, 0, -12);       // Sign-extended immediate
        8:  return sw(2, 31, 0);
        9:  return lui(3, 32'h12345);
        10: return addi(3, 3, 32'h678);
        11: return sw(3, 31, 0);
        12: return addi(0, 0, 5);         // Write to x0 is dropped
        13: return sw(0, 31, 0);
        14: return alu(0, 0, 4, 1, 2);    // ADD
        15: return sw(4, 31, 0);
        16: return alu(32, 0, 4, 1, 2);   // SUB
        17: return sw(4, 31, 0);
        18: return alu(0, 7, 4, 3, 2);    // AND
        19: return sw(4, 31, 0);
        20: return alu(0, 6, 4, 1, 2);    // OR
        21: return sw(4, 31, 0);
        22: return alu(0, 4, 4, 3, 1);    // XOR
        23: return sw(4, 31, 0);
        24: return alu(0, 2, 4, 2, 1);    // SLT, negative first
        25: return sw(4, 31, 0);
        26: return alu(0, 2, 4, 1, 2);
        27: return sw(4, 31, 0);
        28: return addi(6, 0, 32'h400);
        29: return sw(3, 6, 0);
        30: return lw(7, 6, 0);
        31: return sw(7, 31, 0);
        32: return sw(2, 6, 4);
        33: return sw(1, 6, 0);           // Overwrite the first word
        34: return lw(7, 6, 0);
        35: return sw(7, 31, 0);
        36: return lw(8, 6, 4);
        37: return sw(8, 31, 0);
        38: return branch(0, 1, 2, 8);    // BEQ not taken
        39: return sw(1, 31, 0);
        40: return branch(0, 1, 1, 8);    // BEQ taken
        41: return sw(2, 31, 0);
        42: return branch(1, 1, 1, 8);    // BNE not taken
        43: return sw(3, 31, 0);
        44: return branch(1, 1, 2, 8);    // BNE taken
        45: return sw(2, 31, 0);
        46: return jal(9, 8);             // Links 47 * 4
        47: return sw(2, 31, 0);
        48: return sw(9, 31, 0);
        49: return addi(11, 0, 3);
        50: return sw(11, 31, 0);         // Loop top
        51: return addi(11, 11, -1);
        52: return branch(1, 11, 0, -8);
        53: return sw(11, 31, 0);
        54: return jal(0, 0);             // Park here
        default: return addi(0, 0, 0);
    endcase
endfunction

localparam int ExpectedCount = 24;

// Host writes in program order
localparam logic [31:0] ExpectedValues [ExpectedCount] = '{
    32'h0000_07f0, 32'h0000_0000, 32'h0000_0055, 32'h0000_0000,
    32'hffff_fff4, 32'h1234_5678, 32'h0000_0000,
    32'hffff_fffb,                  // 7 + -12
    32'h0000_0013,                  // 7 - -12
    32'h1234_5670, 32'hffff_fff7, 32'h1234_567f,
    32'h0000_0001, 32'h0000_0000,
    32'h1234_5678, 32'h0000_0007, 32'hffff_fff4,
    32'h0000_0007, 32'h1234_5678,   // Only the not-taken paths store
    32'h0000_00bc,
    32'h0000_0003, 32'h0000_0002, 32'h0000_0001, 32'h0000_0000
};

`endif

// File: testbench/CoreTb.sv
`timescale 1ns/1ps

module CoreTb;
    localparam int MemoryAddrWidth = 10;
    localparam int ResetCycle = 40;
    localparam int ClockPeriod = 100;
    localparam int DriveDelay = 10;      // Inputs change this long after the rising edge
    localparam int MaxAckDelay = 3;
    localparam int CyclesPerTest = 200;  // Generous bound for the longest gap between host writes

    `include "CoreProgram.svh"

    localparam int TimeoutCycles = 4 + ResetCycle + ExpectedCount * CyclesPerTest;

    logic clk;
    logic rst;
    logic [31:0] hostIoValue;
    logic memReq;
    logic [MemoryAddrWidth-1:0] memAddr;
    logic memIsWrite;
    logic [31:0] memWriteValue;
    logic memAck;
    logic [31:0] memReadValue;

    logic [31:0] memory [2**MemoryAddrWidth];
    integer seed;
    int passCount;
    int failCount;

    // Port state one falling edge earlier
    logic prevReq;
    logic prevAck;
    logic prevIsWrite;
    logic [MemoryAddrWidth-1:0] prevAddr;
    logic [31:0] prevWriteValue;

    Core #(
        .MemoryAddrWidth(MemoryAddrWidth),
        .ResetCycle(ResetCycle)
    ) Core_inst (
        .clk(clk),
        .rst(rst),
        .hostIoValue(hostIoValue),
        .memReq(memReq),
        .memAddr(memAddr),
        .memIsWrite(memIsWrite),
        .memWriteValue(memWriteValue),
        .memAck(memAck),
        .memReadValue(memReadValue)
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    // Four-phase memory, sampled once the core outputs have settled
    initial begin
        int ackDelay;
        seed = 32'ha5d4;
        memAck = 1'b0;
        memReadValue = '0;
        for (int i = 0; i < 2**MemoryAddrWidth; i++) begin
            memory[i] = 32'h5a5a_0000 ^ i;
        end
        for (int i = 0; i < ProgramLength; i++) begin
            memory[i] = programWord(i);
        end
        forever begin
            @(posedge clk);
            #DriveDelay;
            if (memReq && !memAck) begin
                ackDelay = $unsigned($random(seed)) % (MaxAckDelay + 1);
                repeat (ackDelay) begin
                    @(posedge clk);
                    #DriveDelay;
                end
                if (memIsWrite) begin
                    memory[memAddr] = memWriteValue;
                end else begin
                    memReadValue = memory[memAddr];
                end
                memAck = 1'b1;
            end else if (!memReq && memAck) begin
                memAck = 1'b0;   // Request gone, close the handshake
            end
        end
    end

    // Handshake rules on the memory port
    always @(negedge clk) begin
        if (!rst) begin
            if (memReq === 1'b1 && prevReq === 1'b0 && prevAck === 1'b1) begin
                $display("Protocol error: memReq rose again before memAck fell");
                failCount++;
            end
            if (memReq === 1'b1 && prevReq === 1'b1
                    && (memAddr !== prevAddr || memIsWrite !== prevIsWrite
                        || memWriteValue !== prevWriteValue)) begin
                $display("Protocol error: request fields changed while memReq was high");
                failCount++;
            end
        end
        prevReq = memReq;
        prevAck = memAck;
        prevAddr = memAddr;
        prevIsWrite = memIsWrite;
        prevWriteValue = memWriteValue;
    end

    initial begin
        #(TimeoutCycles * ClockPeriod);
        $display("Timeout: the core stopped writing hostIoValue before all %0d tests finished",
                 ExpectedCount);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0] lastValue;
        rst = 1'b1;
        passCount = 0;
        failCount = 0;
        repeat (4) @(posedge clk);
        #DriveDelay;
        rst = 1'b0;
        lastValue = '0;   // hostIoValue after reset
        for (int n = 0; n < ExpectedCount; n++) begin
            @(negedge clk);
            while (hostIoValue === lastValue) begin
                @(negedge clk);
            end
            lastValue = hostIoValue;
            if (hostIoValue !== ExpectedValues[n]) begin
                $display("Mismatch in test %0d: hostIoValue = %h, expected %h",
                         n, hostIoValue, ExpectedValues[n]);
                failCount++;
            end else begin
                $display("Test %0d ok: hostIoValue = %h", n, hostIoValue);
                passCount++;
            end
        end
        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end
endmodule

// File: verilog/Core.sv
`timescale 1ns/1ps

module Core #(
    parameter int MemoryAddrWidth = 16,
    parameter int ResetCycle = 40
)(
    input  logic clk,
    input  logic rst,
    output logic [CoreTypes::XLEN-1:0] hostIoValue,
    output logic memReq,
    output logic [MemoryAddrWidth-1:0] memAddr,
    output logic memIsWrite,
    output logic [CoreTypes::XLEN-1:0] memWriteValue,
    input  logic memAck,
    input  logic [CoreTypes::XLEN-1:0] memReadValue
);
    logic coreRst;

    // Memory unit requests
    logic fetchReq;
    logic [CoreTypes::XLEN-1:0] fetchAddr;
    logic fetchDone;
    logic [CoreTypes::XLEN-1:0] fetchData;
    logic dataReq;
    logic [CoreTypes::XLEN-1:0] dataAddr;
    logic dataIsWrite;
    logic [CoreTypes::XLEN-1:0] dataWriteValue;
    logic dataDone;
    logic [CoreTypes::XLEN-1:0] dataReadValue;

    // Register file
    logic [CoreTypes::RegAddrWidth-1:0] readAddrA;
    logic [CoreTypes::RegAddrWidth-1:0] readAddrB;
    logic [CoreTypes::XLEN-1:0] readDataA;
    logic [CoreTypes::XLEN-1:0] readDataB;
    logic writeEnable;
    logic [CoreTypes::RegAddrWidth-1:0] writeAddr;
    logic [CoreTypes::XLEN-1:0] writeData;

    // Decode to execute
    logic decodedValid;
    logic [CoreTypes::XLEN-1:0] pc;
    logic [CoreTypes::XLEN-1:0] operandA;
    logic [CoreTypes::XLEN-1:0] operandB;
    logic [CoreTypes::XLEN-1:0] immediate;
    CoreTypes::AluOp aluOp;
    CoreTypes::MemOp decodedMemOp;
    CoreTypes::BranchOp branchOp;
    logic useImmediate;
    logic [CoreTypes::RegAddrWidth-1:0] decodedDestReg;
    logic decodedWritesReg;

    // Execute to result, and retire back to decode
    logic executedValid;
    logic [CoreTypes::XLEN-1:0] aluResult;
    logic [CoreTypes::XLEN-1:0] storeValue;
    CoreTypes::MemOp memOp;
    logic [CoreTypes::RegAddrWidth-1:0] destReg;
    logic writesReg;
    logic [CoreTypes::XLEN-1:0] nextPc;
    logic retire;
    logic [CoreTypes::XLEN-1:0] retirePc;

    ResetSequencer #(
        .ResetCycle(ResetCycle)
    ) m_ResetSequencer (
        .*
    );

    MemoryAccessUnit #(
        .MemoryAddrWidth(MemoryAddrWidth)
    ) m_MemoryAccessUnit (
        .rst(coreRst),
        .*
    );

    RegFile m_RegFile(
        .rst(coreRst),   // Clear sweep runs during the stretch
        .*
    );

    DecodeStage m_DecodeStage(
        .rst(coreRst),
        .nextPc(retirePc),
        .memOp(decodedMemOp),
        .destReg(decodedDestReg),
        .writesReg(decodedWritesReg),
        .*
    );

    ExecuteStage m_ExecuteStage(
        .rst(coreRst),
        .*
    );

    ResultStage m_ResultStage(
        .rst(coreRst),
        .*
    );
endmodule

// File: verilog/CoreTypes.sv
package CoreTypes;

    localparam int XLEN = 32;           // Data and register width
    localparam int RegAddrWidth = 5;

    // Stores here update hostIoValue and never reach memory
    localparam logic [XLEN-1:0] HostIoAddr = 32'h0000_07f0;   // Reachable with one ADDI

    // RV32I major opcodes
    localparam logic [6:0] OpcodeOp     = 7'b0110011;
    localparam logic [6:0] OpcodeOpImm  = 7'b0010011;
    localparam logic [6:0] OpcodeLui    = 7'b0110111;
    localparam logic [6:0] OpcodeLoad   = 7'b0000011;
    localparam logic [6:0] OpcodeStore  = 7'b0100011;
    localparam logic [6:0] OpcodeBranch = 7'b1100011;
    localparam logic [6:0] OpcodeJal    = 7'b1101111;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluPassB        // Operand B straight through, for LUI
    } AluOp;

    typedef enum logic [1:0] {
        MemNone,
        MemLoad,
        MemStore
    } MemOp;

    typedef enum logic [1:0] {
        BranchNone,
        BranchEq,
        BranchNe,
        BranchJump
    } BranchOp;

endpackage

// File: verilog/DecodeStage.sv
`timescale 1ns/1ps

module DecodeStage (
    input  logic clk,
    input  logic rst,
    input  logic retire,
    input  logic [CoreTypes::XLEN-1:0] nextPc,
    output logic fetchReq,
    output logic [CoreTypes::XLEN-1:0] fetchAddr,
    input  logic fetchDone,
    input  logic [CoreTypes::XLEN-1:0] fetchData,
    output logic [CoreTypes::RegAddrWidth-1:0] readAddrA,
    output logic [CoreTypes::RegAddrWidth-1:0] readAddrB,
    input  logic [CoreTypes::XLEN-1:0] readDataA,
    input  logic [CoreTypes::XLEN-1:0] readDataB,
    output logic decodedValid,
    output logic [CoreTypes::XLEN-1:0] pc,
    output logic [CoreTypes::XLEN-1:0] operandA,
    output logic [CoreTypes::XLEN-1:0] operandB,
    output logic [CoreTypes::XLEN-1:0] immediate,
    output CoreTypes::AluOp aluOp,
    output CoreTypes::MemOp memOp,
    output CoreTypes::BranchOp branchOp,
    output logic useImmediate,
    output logic [CoreTypes::RegAddrWidth-1:0] destReg,
    output logic writesReg
);
    logic [CoreTypes::XLEN-1:0] instr;
    logic decodePending;                // Word captured, decode next cycle
    logic [CoreTypes::XLEN-1:0] decImm;
    CoreTypes::AluOp decAluOp;
    CoreTypes::MemOp decMemOp;
    CoreTypes::BranchOp decBranchOp;
    logic decUseImm;
    logic decWritesReg;

    assign fetchAddr = pc;
    assign readAddrA = instr[19:15];
    assign readAddrB = instr[24:20];

    always_comb begin
        decImm = {{20{instr[31]}}, instr[31:20]};   // I format
        decAluOp = CoreTypes::AluAdd;
        decMemOp = CoreTypes::MemNone;
        decBranchOp = CoreTypes::BranchNone;
        decUseImm = 1'b0;
        decWritesReg = 1'b0;
        case (instr[6:0])
            CoreTypes::OpcodeOp: begin
                decWritesReg = 1'b1;
                case (instr[14:12])
                    3'b000: decAluOp = instr[30] ? CoreTypes::AluSub : CoreTypes::AluAdd;
                    3'b010: decAluOp = CoreTypes::AluSlt;
                    3'b100: decAluOp = CoreTypes::AluXor;
                    3'b110: decAluOp = CoreTypes::AluOr;
                    default: decAluOp = CoreTypes::AluAnd;
                endcase
            end
            CoreTypes::OpcodeOpImm: begin   // ADDI only
                decUseImm = 1'b1;
                decWritesReg = 1'b1;
            end
            CoreTypes::OpcodeLui: begin
                decImm = {instr[31:12], 12'b0};
                decAluOp = CoreTypes::AluPassB;
                decUseImm = 1'b1;
                decWritesReg = 1'b1;
            end
            CoreTypes::OpcodeLoad: begin
                decMemOp = CoreTypes::MemLoad;
                decUseImm = 1'b1;
                decWritesReg = 1'b1;
            end
            CoreTypes::OpcodeStore: begin
                decImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                decMemOp = CoreTypes::MemStore;
                decUseImm = 1'b1;
            end
            CoreTypes::OpcodeBranch: begin
                decImm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                decBranchOp = instr[12] ? CoreTypes::BranchNe : CoreTypes::BranchEq;
            end
            CoreTypes::OpcodeJal: begin
                decImm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                decBranchOp = CoreTypes::BranchJump;
                decWritesReg = 1'b1;
            end
            default: decWritesReg = 1'b0;   // Anything else passes as a no-op
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            fetchReq <= 1'b1;   // Served once the memory unit leaves reset
            decodePending <= 1'b0;
            decodedValid <= 1'b0;
        end else begin
            decodePending <= fetchDone;
            decodedValid <= decodePending;
            if (fetchDone) begin
                fetchReq <= 1'b0;
            end
            if (retire) begin
                pc <= nextPc;
                fetchReq <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instr <= fetchData;
        end
        if (decodePending) begin
            operandA <= readDataA;   // Register file read sampled here
            operandB <= readDataB;
            immediate <= decImm;
            aluOp <= decAluOp;
            memOp <= decMemOp;
            branchOp <= decBranchOp;
            useImmediate <= decUseImm;
            destReg <= instr[11:7];
            writesReg <= decWritesReg;
        end
    end
endmodule

// File: verilog/ExecuteStage.sv
`timescale 1ns/1ps

module ExecuteStage (
    input  logic clk,
    input  logic rst,
    input  logic decodedValid,
    input  logic [CoreTypes::XLEN-1:0] pc,
    input  logic [CoreTypes::XLEN-1:0] operandA,
    input  logic [CoreTypes::XLEN-1:0] operandB,
    input  logic [CoreTypes::XLEN-1:0] immediate,
    input  CoreTypes::AluOp aluOp,
    input  CoreTypes::MemOp decodedMemOp,
    input  CoreTypes::BranchOp branchOp,
    input  logic useImmediate,
    input  logic [CoreTypes::RegAddrWidth-1:0] decodedDestReg,
    input  logic decodedWritesReg,
    output logic executedValid,
    output logic [CoreTypes::XLEN-1:0] aluResult,
    output logic [CoreTypes::XLEN-1:0] storeValue,
    output CoreTypes::MemOp memOp,
    output logic [CoreTypes::RegAddrWidth-1:0] destReg,
    output logic writesReg,
    output logic [CoreTypes::XLEN-1:0] nextPc
);
    logic [CoreTypes::XLEN-1:0] aluB;
    logic [CoreTypes::XLEN-1:0] aluOut;
    logic [CoreTypes::XLEN-1:0] pcPlus4;
    logic taken;

    assign aluB = useImmediate ? immediate : operandB;
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (aluOp)
            CoreTypes::AluAdd: aluOut = operandA + aluB;
            CoreTypes::AluSub: aluOut = operandA - aluB;
            CoreTypes::AluAnd: aluOut = operandA & aluB;
            CoreTypes::AluOr:  aluOut = operandA | aluB;
            CoreTypes::AluXor: aluOut = operandA ^ aluB;
            CoreTypes::AluSlt: aluOut = {{(CoreTypes::XLEN-1){1'b0}},
                                         $signed(operandA) < $signed(aluB)};
            default:           aluOut = aluB;   // PASSB for LUI
        endcase
        case (branchOp)
            CoreTypes::BranchEq:   taken = (operandA == operandB);
            CoreTypes::BranchNe:   taken = (operandA != operandB);
            CoreTypes::BranchJump: taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            executedValid <= 1'b0;
        end else begin
            executedValid <= decodedValid;
        end
    end

    always_ff @(posedge clk) begin
        if (decodedValid) begin
            aluResult <= (branchOp == CoreTypes::BranchJump) ? pcPlus4 : aluOut;   // JAL link
            storeValue <= operandB;
            memOp <= decodedMemOp;
            destReg <= decodedDestReg;
            writesReg <= decodedWritesReg;
            nextPc <= taken ? pc + immediate : pcPlus4;
        end
    end
endmodule

// File: verilog/MemoryAccessUnit.sv
`timescale 1ns/1ps

module MemoryAccessUnit #(
    parameter int MemoryAddrWidth = 16
)(
    input  logic clk,
    input  logic rst,
    input  logic fetchReq,
    input  logic [CoreTypes::XLEN-1:0] fetchAddr,
    output logic fetchDone,
    output logic [CoreTypes::XLEN-1:0] fetchData,
    input  logic dataReq,
    input  logic [CoreTypes::XLEN-1:0] dataAddr,
    input  logic dataIsWrite,
    input  logic [CoreTypes::XLEN-1:0] dataWriteValue,
    output logic dataDone,
    output logic [CoreTypes::XLEN-1:0] dataReadValue,
    output logic memReq,
    output logic [MemoryAddrWidth-1:0] memAddr,
    output logic memIsWrite,
    output logic [CoreTypes::XLEN-1:0] memWriteValue,
    input  logic memAck,
    input  logic [CoreTypes::XLEN-1:0] memReadValue
);
    typedef enum logic [1:0] {
        StateIdle,
        StateWaitAckHigh,
        StateWaitAckLow,
        StateDone
    } State;

    State state;
    logic [CoreTypes::XLEN-1:0] reqAddr;
    logic [CoreTypes::XLEN-1:0] readValue;   // Captured while ack is high

    assign reqAddr = fetchReq ? fetchAddr : dataAddr;   // Never both at once

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
            memReq <= 1'b0;
        end else begin
            case (state)
                StateIdle: begin
                    if (fetchReq || dataReq) begin
                        memReq <= 1'b1;
                        state <= StateWaitAckHigh;
                    end
                end
                StateWaitAckHigh: begin
                    if (memAck) begin
                        memReq <= 1'b0;
                        state <= StateWaitAckLow;
                    end
                end
                StateWaitAckLow: begin
                    if (!memAck) begin
                        state <= StateDone;
                    end
                end
                default: state <= StateIdle;   // Done lasts one cycle
            endcase
        end
    end

    // Address and data stay frozen once the request is out
    always_ff @(posedge clk) begin
        if (state == StateIdle) begin
            memAddr <= reqAddr[MemoryAddrWidth+1:2];   // Byte to word address
            memIsWrite <= !fetchReq && dataIsWrite;
            memWriteValue <= dataWriteValue;
        end
        if (state == StateWaitAckHigh && memAck) begin
            readValue <= memReadValue;
        end
    end

    assign fetchDone = (state == StateDone) && fetchReq;
    assign dataDone = (state == StateDone) && dataReq;
    assign fetchData = readValue;
    assign dataReadValue = readValue;
endmodule

// File: verilog/RegFile.sv
`timescale 1ns/1ps

module RegFile (
    input  logic clk,
    input  logic rst,
    input  logic [CoreTypes::RegAddrWidth-1:0] readAddrA,
    input  logic [CoreTypes::RegAddrWidth-1:0] readAddrB,
    output logic [CoreTypes::XLEN-1:0] readDataA,
    output logic [CoreTypes::XLEN-1:0] readDataB,
    input  logic writeEnable,
    input  logic [CoreTypes::RegAddrWidth-1:0] writeAddr,
    input  logic [CoreTypes::XLEN-1:0] writeData
);
    logic [CoreTypes::XLEN-1:0] regs [2**CoreTypes::RegAddrWidth];
    logic [CoreTypes::RegAddrWidth-1:0] clearAddr;

    // The sweep pointer wraps, so any 32 reset cycles clear every entry
    always_ff @(posedge clk) begin
        if (rst) begin
            regs[clearAddr] <= '0;
            clearAddr <= clearAddr + 1'b1;
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];   // x0 reads zero
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
endmodule

// File: verilog/ResetSequencer.sv
`timescale 1ns/1ps

module ResetSequencer #(
    parameter int ResetCycle = 40
)(
    input  logic clk,
    input  logic rst,
    output logic coreRst
);
    localparam int CountWidth = $clog2(ResetCycle + 1);

    logic [CountWidth-1:0] count;   // Cycles left in the stretch

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= CountWidth'(ResetCycle);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign coreRst = rst || (count != '0);
endmodule

// File: verilog/ResultStage.sv
`timescale 1ns/1ps

module ResultStage (
    input  logic clk,
    input  logic rst,
    input  logic executedValid,
    input  logic [CoreTypes::XLEN-1:0] aluResult,
    input  logic [CoreTypes::XLEN-1:0] storeValue,
    input  CoreTypes::MemOp memOp,
    input  logic [CoreTypes::RegAddrWidth-1:0] destReg,
    input  logic writesReg,
    input  logic [CoreTypes::XLEN-1:0] nextPc,
    output logic dataReq,
    output logic [CoreTypes::XLEN-1:0] dataAddr,
    output logic dataIsWrite,
    output logic [CoreTypes::XLEN-1:0] dataWriteValue,
    input  logic dataDone,
    input  logic [CoreTypes::XLEN-1:0] dataReadValue,
    output logic writeEnable,
    output logic [CoreTypes::RegAddrWidth-1:0] writeAddr,
    output logic [CoreTypes::XLEN-1:0] writeData,
    output logic [CoreTypes::XLEN-1:0] hostIoValue,
    output logic retire,
    output logic [CoreTypes::XLEN-1:0] retirePc
);
    logic isHostStore;

    assign isHostStore = (memOp == CoreTypes::MemStore) && (aluResult == CoreTypes::HostIoAddr);

    // Execute outputs stay stable until the next decode, which waits for retire
    always_ff @(posedge clk) begin
        if (rst) begin
            dataReq <= 1'b0;
            writeEnable <= 1'b0;
            retire <= 1'b0;
            hostIoValue <= '0;
        end else begin
            writeEnable <= 1'b0;
            retire <= 1'b0;
            if (executedValid) begin
                if (isHostStore) begin
                    hostIoValue <= storeValue;   // No memory access
                    retire <= 1'b1;
                end else if (memOp != CoreTypes::MemNone) begin
                    dataReq <= 1'b1;
                end else begin
                    writeEnable <= writesReg;
                    retire <= 1'b1;
                end
            end
            if (dataDone) begin
                dataReq <= 1'b0;
                writeEnable <= (memOp == CoreTypes::MemLoad) && writesReg;
                retire <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (executedValid) begin
            dataAddr <= aluResult;
            dataIsWrite <= (memOp == CoreTypes::MemStore);
            dataWriteValue <= storeValue;
            writeAddr <= destReg;
            writeData <= aluResult;
            retirePc <= nextPc;
        end
        if (dataDone) begin
            writeData <= dataReadValue;   // Load result replaces the address
        end
    end
endmodule
